// ==== bench/tb_pipe_controller.sv ====
`include "ctrl_params.svh"

module tb_pipe_controller;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  localparam int N_CYCLES   = 2000;
  localparam int CLK_PERIOD = 8;

  // expected control word of one instruction
  typedef struct packed {
    logic [2:0] imm_src;
    logic       jal;
    logic [3:0] alu_ctrl;
    logic       alu_src;
    logic       imm_plus_src;
    logic [1:0] result_src;
    logic       mem_req;
    logic       mem_write;
    logic [1:0] mem_size;
    logic       load_signed;
    logic       reg_write;
    logic       branch;
    logic       jalr;
    logic       ecall;
    logic [2:0] funct3;
  } ctrl_ref_t;

  logic                    clk = 1'b0;
  logic                    rst_n = 1'b0;
  logic [`CTRL_INST_W-1:0] inst_d = 32'h0000_0013;
  logic                    zero_e = 1'b0;
  logic                    neg_e = 1'b0;
  logic                    neg_u_e = 1'b0;
  logic                    flush_e = 1'b0;

  logic [2:0] imm_src_d;
  logic       jal_d;
  logic [3:0] alu_ctrl_e;
  logic       alu_src_e;
  logic       imm_plus_src_e;
  logic [1:0] pc_src_e;
  logic [1:0] result_src_e;
  logic       mem_req_m;
  logic       mem_write_m;
  logic [1:0] mem_size_m;
  logic       load_signed_m;
  logic [1:0] result_src_m;
  logic       reg_write_m;
  logic [1:0] result_src_w;
  logic       reg_write_w;

  // reference pipeline with one entry per stage
  ctrl_ref_t  exp_d;
  ctrl_ref_t  exp_e;
  ctrl_ref_t  exp_m;
  ctrl_ref_t  exp_w;
  logic [1:0] pc_exp;
  logic       rst_q = 1'b0;
  logic [2:0] flush_q = 3'b000;

  int errors = 0;
  int hit_reset = 0;
  int hit_sub = 0;
  int hit_srl = 0;
  int hit_sra = 0;
  int hit_load = 0;
  int hit_store = 0;
  int hit_taken = 0;
  int hit_jalr = 0;
  int hit_trap = 0;
  int hit_flush = 0;

  // valid opcodes plus a few that must decode to a nop
  logic [6:0] opc_table [14] = '{OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_LUI,
                                 OPC_AUIPC, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_SYSTEM,
                                 7'b0000000, 7'b1111111, 7'b0001111, 7'b1010011};

  pipe_controller i_dut (
    .clk             (clk),
    .i_rst_n         (rst_n),
    .i_inst_d        (inst_d),
    .i_zero_e        (zero_e),
    .i_neg_e         (neg_e),
    .i_neg_u_e       (neg_u_e),
    .i_flush_e       (flush_e),
    .o_imm_src_d     (imm_src_d),
    .o_jal_d         (jal_d),
    .o_alu_ctrl_e    (alu_ctrl_e),
    .o_alu_src_e     (alu_src_e),
    .o_imm_plus_src_e(imm_plus_src_e),
    .o_pc_src_e      (pc_src_e),
    .o_result_src_e  (result_src_e),
    .o_mem_req_m     (mem_req_m),
    .o_mem_write_m   (mem_write_m),
    .o_mem_size_m    (mem_size_m),
    .o_load_signed_m (load_signed_m),
    .o_result_src_m  (result_src_m),
    .o_reg_write_m   (reg_write_m),
    .o_result_src_w  (result_src_w),
    .o_reg_write_w   (reg_write_w)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic ctrl_ref_t decode_ref(input logic [`CTRL_INST_W-1:0] inst);
    ctrl_ref_t  r;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       is_load, is_store, is_op_imm, is_op, is_lui;
    logic       is_auipc, is_br, is_jal, is_jalr, is_sys;
    opc = inst[6:0];
    f3 = inst[14:12];
    is_load = (opc == OPC_LOAD);
    is_store = (opc == OPC_STORE);
    is_op_imm = (opc == OPC_OP_IMM);
    is_op = (opc == OPC_OP);
    is_lui = (opc == OPC_LUI);
    is_auipc = (opc == OPC_AUIPC);
    is_br = (opc == OPC_BRANCH);
    is_jal = (opc == OPC_JAL);
    is_jalr = (opc == OPC_JALR);
    is_sys = (opc == OPC_SYSTEM);
    r = '0;
    r.funct3 = f3;
    r.jal = is_jal;
    r.jalr = is_jalr;
    r.branch = is_br;
    r.ecall = is_sys && (f3 == 3'd0);
    r.alu_src = is_load || is_store || is_op_imm || is_lui || is_jalr;
    r.imm_plus_src = is_jalr;
    r.mem_req = is_load || is_store;
    r.mem_write = is_store;
    r.mem_size = r.mem_req ? f3[1:0] : 2'd0;
    r.load_signed = is_load && !f3[2];
    r.reg_write = is_load || is_op_imm || is_op || is_lui || is_auipc || is_jal || is_jalr;
    r.imm_src = is_store ? IMM_S : is_br ? IMM_B : (is_lui || is_auipc) ? IMM_U
              : is_jal ? IMM_J : IMM_I;
    r.result_src = is_load ? RES_MEM : is_auipc ? RES_IMM_PLUS
                 : (is_jal || is_jalr) ? RES_PC4 : RES_ALU;
    r.alu_ctrl = ALU_ADD;
    if (is_br) begin
      r.alu_ctrl = ALU_SUB;
    end else if (is_lui) begin
      r.alu_ctrl = ALU_PASS_B;
    end else if (is_op || is_op_imm) begin
      // sub only for register ops and shift type from funct7 bit 5
      case (f3)
        3'd0: r.alu_ctrl = (is_op && inst[30]) ? ALU_SUB : ALU_ADD;
        3'd1: r.alu_ctrl = ALU_SLL;
        3'd2: r.alu_ctrl = ALU_SLT;
        3'd3: r.alu_ctrl = ALU_SLTU;
        3'd4: r.alu_ctrl = ALU_XOR;
        3'd5: r.alu_ctrl = inst[30] ? ALU_SRA : ALU_SRL;
        3'd6: r.alu_ctrl = ALU_OR;
        default: r.alu_ctrl = ALU_AND;
      endcase
    end
    return r;
  endfunction

  function automatic logic [1:0] expect_pc_src(input ctrl_ref_t e, input logic z,
                                               input logic n, input logic nu);
    logic       taken;
    logic [1:0] pc;
    case (e.funct3)
      3'b000: taken = z;
      3'b001: taken = !z;
      3'b100: taken = n;
      3'b101: taken = !n;
      3'b110: taken = nu;
      3'b111: taken = !nu;
      default: taken = 1'b0;
    endcase
    if (e.ecall) begin
      pc = PC_TRAP;
    end else if (e.jalr) begin
      pc = PC_JALR;
    end else if (e.branch && taken) begin
      pc = PC_TARGET;
    end else begin
      pc = PC_PLUS4;
    end
    return pc;
  endfunction

  task automatic flag_mismatch(input string name, input logic [3:0] exp_v,
                               input logic [3:0] act_v);
    errors++;
    $display("mismatch %s: expected 0x%h, got 0x%h at %0t", name, exp_v, act_v, $time);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic require_hit(input string name, input int hits);
    if (hits == 0) begin
      note_failure({"behavior never reached: ", name});
    end
  endtask

  assign exp_d = decode_ref(inst_d);
  assign pc_exp = expect_pc_src(exp_e, zero_e, neg_e, neg_u_e);

  // flush or reset turns the EX entry into a nop
  always @(posedge clk) begin
    rst_q <= !rst_n;
    flush_q <= {flush_q[1:0], flush_e};
    exp_e <= (!rst_n || flush_e) ? '0 : exp_d;
    exp_m <= !rst_n ? '0 : exp_e;
    exp_w <= !rst_n ? '0 : exp_m;
  end

  always @(posedge clk) begin
    if (rst_q) begin
      hit_reset <= hit_reset + 1;
    end
    if (rst_n) begin
      if (exp_e.alu_ctrl == ALU_SUB && !exp_e.branch) hit_sub <= hit_sub + 1;
      if (exp_e.alu_ctrl == ALU_SRL) hit_srl <= hit_srl + 1;
      if (exp_e.alu_ctrl == ALU_SRA) hit_sra <= hit_sra + 1;
      if (exp_m.mem_req && !exp_m.mem_write) hit_load <= hit_load + 1;
      if (exp_m.mem_write) hit_store <= hit_store + 1;
      if (exp_e.branch && pc_exp == PC_TARGET) hit_taken <= hit_taken + 1;
      if (exp_e.jalr) hit_jalr <= hit_jalr + 1;
      if (exp_e.ecall) hit_trap <= hit_trap + 1;
      if (flush_e && (exp_d.reg_write || exp_d.mem_req)) hit_flush <= hit_flush + 1;
    end
  end

  a_reset: assert property (@(posedge clk) rst_q |-> (!mem_req_m && !mem_write_m
    && !reg_write_m && !reg_write_w && pc_src_e == PC_PLUS4))
    else note_failure("reset: memory request, write enables or pc source not idle");

  a_imm_src_d: assert property (@(posedge clk) imm_src_d == exp_d.imm_src)
    else flag_mismatch("o_imm_src_d", 4'($sampled(exp_d.imm_src)),
                       4'($sampled(imm_src_d)));
  a_jal_d: assert property (@(posedge clk) jal_d == exp_d.jal)
    else flag_mismatch("o_jal_d", 4'($sampled(exp_d.jal)), 4'($sampled(jal_d)));
  a_alu_ctrl_e: assert property (@(posedge clk) rst_n |-> alu_ctrl_e == exp_e.alu_ctrl)
    else flag_mismatch("o_alu_ctrl_e", 4'($sampled(exp_e.alu_ctrl)),
                       4'($sampled(alu_ctrl_e)));
  a_alu_src_e: assert property (@(posedge clk) rst_n |-> alu_src_e == exp_e.alu_src)
    else flag_mismatch("o_alu_src_e", 4'($sampled(exp_e.alu_src)),
                       4'($sampled(alu_src_e)));
  a_imm_plus_e: assert property (@(posedge clk)
    rst_n |-> imm_plus_src_e == exp_e.imm_plus_src)
    else flag_mismatch("o_imm_plus_src_e", 4'($sampled(exp_e.imm_plus_src)),
                       4'($sampled(imm_plus_src_e)));
  a_result_e: assert property (@(posedge clk) rst_n |-> result_src_e == exp_e.result_src)
    else flag_mismatch("o_result_src_e", 4'($sampled(exp_e.result_src)),
                       4'($sampled(result_src_e)));
  a_pc_src_e: assert property (@(posedge clk) rst_n |-> pc_src_e == pc_exp)
    else flag_mismatch("o_pc_src_e", 4'($sampled(pc_exp)), 4'($sampled(pc_src_e)));
  a_mem_req_m: assert property (@(posedge clk) rst_n |-> mem_req_m == exp_m.mem_req)
    else flag_mismatch("o_mem_req_m", 4'($sampled(exp_m.mem_req)),
                       4'($sampled(mem_req_m)));
  a_mem_write_m: assert property (@(posedge clk) rst_n |-> mem_write_m == exp_m.mem_write)
    else flag_mismatch("o_mem_write_m", 4'($sampled(exp_m.mem_write)),
                       4'($sampled(mem_write_m)));
  a_mem_size_m: assert property (@(posedge clk) rst_n |-> mem_size_m == exp_m.mem_size)
    else flag_mismatch("o_mem_size_m", 4'($sampled(exp_m.mem_size)),
                       4'($sampled(mem_size_m)));
  a_signed_m: assert property (@(posedge clk) rst_n |-> load_signed_m == exp_m.load_signed)
    else flag_mismatch("o_load_signed_m", 4'($sampled(exp_m.load_signed)),
                       4'($sampled(load_signed_m)));
  a_result_m: assert property (@(posedge clk) rst_n |-> result_src_m == exp_m.result_src)
    else flag_mismatch("o_result_src_m", 4'($sampled(exp_m.result_src)),
                       4'($sampled(result_src_m)));
  a_reg_write_m: assert property (@(posedge clk) rst_n |-> reg_write_m == exp_m.reg_write)
    else flag_mismatch("o_reg_write_m", 4'($sampled(exp_m.reg_write)),
                       4'($sampled(reg_write_m)));
  a_result_w: assert property (@(posedge clk) rst_n |-> result_src_w == exp_w.result_src)
    else flag_mismatch("o_result_src_w", 4'($sampled(exp_w.result_src)),
                       4'($sampled(result_src_w)));
  a_reg_write_w: assert property (@(posedge clk) rst_n |-> reg_write_w == exp_w.reg_write)
    else flag_mismatch("o_reg_write_w", 4'($sampled(exp_w.reg_write)),
                       4'($sampled(reg_write_w)));

  // killed instruction shows up as a nop in EX, then M, then W
  a_flush_nop: assert property (@(posedge clk) rst_n |->
    (!flush_q[0] || (alu_ctrl_e == ALU_ADD && !alu_src_e && !imm_plus_src_e
                     && result_src_e == RES_ALU && pc_src_e == PC_PLUS4))
    && (!flush_q[1] || (!mem_req_m && !mem_write_m && !reg_write_m))
    && (!flush_q[2] || !reg_write_w))
    else note_failure("flush: flushed instruction was not turned into a nop");

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((N_CYCLES + 20) * CLK_PERIOD);
    note_failure("watchdog expired before the run finished");
    $display("run aborted: %0d errors", errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0] seed;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    logic [31:0] rd;
    seed = 32'h14c4_22ca;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_CYCLES; i++) begin
      seed = lcg_next(seed);
      ra = seed;
      seed = lcg_next(seed);
      rb = seed;
      seed = lcg_next(seed);
      rc = seed;
      seed = lcg_next(seed);
      rd = seed;
      inst_d <= {rb[31:16], rc[31:23], opc_table[int'(ra[31:16]) % 14]};
      zero_e <= rd[31];
      neg_e <= rd[30];
      neg_u_e <= rd[29];
      // about one flush in eight cycles
      flush_e <= (rd[27:25] == 3'd0);
      @(posedge clk);
    end
    // drain the pipe with nops
    inst_d <= 32'h0000_0013;
    flush_e <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    require_hit("reset", hit_reset);
    require_hit("sub", hit_sub);
    require_hit("srl", hit_srl);
    require_hit("sra", hit_sra);
    require_hit("load", hit_load);
    require_hit("store", hit_store);
    require_hit("branch taken", hit_taken);
    require_hit("jalr", hit_jalr);
    require_hit("ecall", hit_trap);
    require_hit("flush", hit_flush);
    $write("run done: %0d errors, hits rst %0d sub %0d srl %0d sra %0d ld %0d ",
           errors, hit_reset, hit_sub, hit_srl, hit_sra, hit_load);
    $display("st %0d br %0d jalr %0d trap %0d flush %0d",
             hit_store, hit_taken, hit_jalr, hit_trap, hit_flush);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/alu_decoder.sv ====
module alu_decoder (
  input  ctrl_pkg::alu_op_e   i_alu_op,
  input  logic [2:0]          i_funct3,
  input  logic                i_opcode_b5,
  input  logic                i_funct7_b5,
  output ctrl_pkg::alu_ctrl_e o_alu_ctrl
);
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  // funct7 bit 5 is immediate on OP_IMM so sub needs OP
  logic is_sub;

  assign is_sub = i_opcode_b5 & i_funct7_b5;

  always_comb begin
    case (i_alu_op)
      ALUOP_ADD_ONLY:   o_alu_ctrl = ALU_ADD;
      ALUOP_BRANCH_CMP: o_alu_ctrl = ALU_SUB;
      ALUOP_PASS_B:     o_alu_ctrl = ALU_PASS_B;
      default: begin
        case (i_funct3)
          F3_ADD_SUB: o_alu_ctrl = is_sub ? ALU_SUB : ALU_ADD;
          F3_SLL:     o_alu_ctrl = ALU_SLL;
          F3_SLT:     o_alu_ctrl = ALU_SLT;
          F3_SLTU:    o_alu_ctrl = ALU_SLTU;
          F3_XOR:     o_alu_ctrl = ALU_XOR;
          // same bit picks arithmetic shift for srai too
          F3_SR:      o_alu_ctrl = i_funct7_b5 ? ALU_SRA : ALU_SRL;
          F3_OR:      o_alu_ctrl = ALU_OR;
          F3_AND:     o_alu_ctrl = ALU_AND;
          default:    o_alu_ctrl = ALU_ADD;
        endcase
      end
    endcase
  end

endmodule

// ==== logic/ctrl_params.svh ====
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction word
`define CTRL_INST_W 32

// alu operation code
`define CTRL_ALU_W 4

`endif

// ==== logic/ctrl_pkg.sv ====
`include "ctrl_params.svh"

package ctrl_pkg;

  // op class from main decoder to alu decoder
  typedef enum logic [1:0] {
    ALUOP_ADD_ONLY   = 2'd0,
    ALUOP_BRANCH_CMP = 2'd1,
    ALUOP_FUNCT      = 2'd2,
    ALUOP_PASS_B     = 2'd3
  } alu_op_e;

  typedef enum logic [`CTRL_ALU_W-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_ctrl_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;

  // writeback mux select
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4, RES_IMM_PLUS} result_src_e;

  // same encoding as funct3[1:0]
  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

  typedef enum logic [1:0] {PC_PLUS4, PC_TARGET, PC_JALR, PC_TRAP} pc_src_e;

  // all zero is a nop
  typedef struct packed {
    alu_ctrl_e   alu_ctrl;
    logic        alu_src;
    logic        imm_plus_src;
    logic        ecall;
    logic [2:0]  funct3;
    logic        branch;
    logic        jalr;
    logic        mem_write;
    logic        mem_req;
    mem_size_e   mem_size;
    logic        load_signed;
    result_src_e result_src;
    logic        reg_write;
  } id_ex_ctrl_t;

  typedef struct packed {
    logic        mem_write;
    logic        mem_req;
    mem_size_e   mem_size;
    logic        load_signed;
    result_src_e result_src;
    logic        reg_write;
  } ex_mem_ctrl_t;

endpackage

// ==== logic/ex_ctrl_stage.sv ====
module ex_ctrl_stage (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_flush,
  // decode side
  input  ctrl_pkg::alu_ctrl_e   i_alu_ctrl,
  input  logic                  i_alu_src,
  input  logic                  i_imm_plus_src,
  input  logic                  i_ecall,
  input  logic [2:0]            i_funct3,
  input  logic                  i_branch,
  input  logic                  i_jalr,
  input  logic                  i_mem_req,
  input  logic                  i_mem_write,
  input  ctrl_pkg::mem_size_e   i_mem_size,
  input  logic                  i_load_signed,
  input  ctrl_pkg::result_src_e i_result_src,
  input  logic                  i_reg_write,
  // alu flags
  input  logic                  i_zero,
  input  logic                  i_neg,
  input  logic                  i_neg_u,
  output ctrl_pkg::alu_ctrl_e   o_alu_ctrl,
  output logic                  o_alu_src,
  output logic                  o_imm_plus_src,
  output ctrl_pkg::result_src_e o_result_src,
  output ctrl_pkg::pc_src_e     o_pc_src,
  output logic                  o_mem_req,
  output logic                  o_mem_write,
  output ctrl_pkg::mem_size_e   o_mem_size,
  output logic                  o_load_signed,
  output logic                  o_reg_write
);
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  id_ex_ctrl_t id_ex_d;
  id_ex_ctrl_t id_ex_q;
  logic        br_cond;

  assign id_ex_d = '{alu_ctrl: i_alu_ctrl, alu_src: i_alu_src,
                     imm_plus_src: i_imm_plus_src, ecall: i_ecall,
                     funct3: i_funct3, branch: i_branch, jalr: i_jalr,
                     mem_write: i_mem_write, mem_req: i_mem_req,
                     mem_size: i_mem_size, load_signed: i_load_signed,
                     result_src: i_result_src, reg_write: i_reg_write};

  // flush loads a bubble
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_flush) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  // branch condition from the sub flags
  always_comb begin
    case (branch_f3_e'(id_ex_q.funct3))
      F3_BEQ:  br_cond = i_zero;
      F3_BNE:  br_cond = ~i_zero;
      F3_BLT:  br_cond = i_neg;
      F3_BGE:  br_cond = ~i_neg;
      F3_BLTU: br_cond = i_neg_u;
      F3_BGEU: br_cond = ~i_neg_u;
      default: br_cond = 1'b0;
    endcase
  end

  always_comb begin
    if (id_ex_q.ecall) begin
      o_pc_src = PC_TRAP;
    end else if (id_ex_q.jalr) begin
      o_pc_src = PC_JALR;
    end else if (id_ex_q.branch && br_cond) begin
      o_pc_src = PC_TARGET;
    end else begin
      o_pc_src = PC_PLUS4;
    end
  end

  assign o_alu_ctrl     = id_ex_q.alu_ctrl;
  assign o_alu_src      = id_ex_q.alu_src;
  assign o_imm_plus_src = id_ex_q.imm_plus_src;
  assign o_result_src   = id_ex_q.result_src;
  assign o_mem_req      = id_ex_q.mem_req;
  assign o_mem_write    = id_ex_q.mem_write;
  assign o_mem_size     = id_ex_q.mem_size;
  assign o_load_signed  = id_ex_q.load_signed;
  assign o_reg_write    = id_ex_q.reg_write;

  // decoder keeps system and branch apart, so trap never masks a branch
  a_ecall_not_branch: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(id_ex_q.ecall && id_ex_q.branch))
    else $error("ex_ctrl_stage: ecall and branch both set in EX");

endmodule

// ==== logic/main_decoder.sv ====
module main_decoder (
  input  rv_isa_pkg::opcode_e   i_opcode,
  input  logic [2:0]            i_funct3,
  output ctrl_pkg::imm_src_e    o_imm_src,
  output ctrl_pkg::alu_op_e     o_alu_op,
  output logic                  o_alu_src,
  output logic                  o_imm_plus_src,
  output logic                  o_mem_req,
  output logic                  o_mem_write,
  output ctrl_pkg::mem_size_e   o_mem_size,
  output logic                  o_load_signed,
  output ctrl_pkg::result_src_e o_result_src,
  output logic                  o_reg_write,
  output logic                  o_branch,
  output logic                  o_jal,
  output logic                  o_jalr,
  output logic                  o_ecall
);
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  always_comb begin
    // nop unless the opcode says otherwise
    o_imm_src      = IMM_I;
    o_alu_op       = ALUOP_ADD_ONLY;
    o_alu_src      = 1'b0;
    o_imm_plus_src = 1'b0;
    o_mem_req      = 1'b0;
    o_mem_write    = 1'b0;
    o_mem_size     = SIZE_BYTE;
    o_load_signed  = 1'b0;
    o_result_src   = RES_ALU;
    o_reg_write    = 1'b0;
    o_branch       = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_ecall        = 1'b0;
    case (i_opcode)
      OPC_LOAD: begin
        o_alu_src     = 1'b1;
        o_mem_req     = 1'b1;
        o_mem_size    = mem_size_e'(i_funct3[1:0]);
        o_load_signed = ~i_funct3[2];
        o_result_src  = RES_MEM;
        o_reg_write   = 1'b1;
      end
      OPC_STORE: begin
        o_imm_src   = IMM_S;
        o_alu_src   = 1'b1;
        o_mem_req   = 1'b1;
        o_mem_write = 1'b1;
        o_mem_size  = mem_size_e'(i_funct3[1:0]);
      end
      OPC_OP_IMM: begin
        o_alu_op    = ALUOP_FUNCT;
        o_alu_src   = 1'b1;
        o_reg_write = 1'b1;
      end
      OPC_OP: begin
        o_alu_op    = ALUOP_FUNCT;
        o_reg_write = 1'b1;
      end
      OPC_LUI: begin
        o_imm_src   = IMM_U;
        o_alu_op    = ALUOP_PASS_B;
        o_alu_src   = 1'b1;
        o_reg_write = 1'b1;
      end
      // pc + imm from the target adder
      OPC_AUIPC: begin
        o_imm_src    = IMM_U;
        o_result_src = RES_IMM_PLUS;
        o_reg_write  = 1'b1;
      end
      OPC_BRANCH: begin
        o_imm_src = IMM_B;
        o_alu_op  = ALUOP_BRANCH_CMP;
        o_branch  = 1'b1;
      end
      OPC_JAL: begin
        o_imm_src    = IMM_J;
        o_jal        = 1'b1;
        o_result_src = RES_PC4;
        o_reg_write  = 1'b1;
      end
      // target adder takes rs1 as base
      OPC_JALR: begin
        o_alu_src      = 1'b1;
        o_imm_plus_src = 1'b1;
        o_jalr         = 1'b1;
        o_result_src   = RES_PC4;
        o_reg_write    = 1'b1;
      end
      OPC_SYSTEM: begin
        o_ecall = (i_funct3 == 3'b000);
      end
      default: begin
      end
    endcase
  end

  // a store must also raise the request
  always_comb begin
    a_write_has_req: assert (!o_mem_write || o_mem_req)
      else $error("main_decoder: mem_write without mem_req");
  end

endmodule

// ==== logic/pipe_controller.sv ====
`include "ctrl_params.svh"

module pipe_controller (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic [`CTRL_INST_W-1:0]  i_inst_d,
  input  logic                     i_zero_e,
  input  logic                     i_neg_e,
  input  logic                     i_neg_u_e,
  input  logic                     i_flush_e,
  output ctrl_pkg::imm_src_e       o_imm_src_d,
  output logic                     o_jal_d,
  output ctrl_pkg::alu_ctrl_e      o_alu_ctrl_e,
  output logic                     o_alu_src_e,
  output logic                     o_imm_plus_src_e,
  output ctrl_pkg::pc_src_e        o_pc_src_e,
  output ctrl_pkg::result_src_e    o_result_src_e,
  output logic                     o_mem_req_m,
  output logic                     o_mem_write_m,
  output ctrl_pkg::mem_size_e      o_mem_size_m,
  output logic                     o_load_signed_m,
  output ctrl_pkg::result_src_e    o_result_src_m,
  output logic                     o_reg_write_m,
  output ctrl_pkg::result_src_e    o_result_src_w,
  output logic                     o_reg_write_w
);
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  // decode stage
  opcode_e      opcode_d;
  logic [2:0]   funct3_d;
  logic         funct7_b5_d;
  alu_op_e      alu_op_d;
  alu_ctrl_e    alu_ctrl_d;
  logic         alu_src_d;
  logic         imm_plus_src_d;
  logic         ecall_d;
  logic         branch_d;
  logic         jalr_d;
  logic         mem_req_d;
  logic         mem_write_d;
  mem_size_e    mem_sz_d;
  logic         load_signed_d;
  result_src_e  result_src_d;
  logic         reg_write_d;
  // memory and writeback fields of the execute stage
  logic         mem_req_e;
  logic         mem_write_e;
  mem_size_e    mem_sz_e;
  logic         load_signed_e;
  logic         reg_write_e;
  ex_mem_ctrl_t ex_mem_e;
  ex_mem_ctrl_t ex_mem_m;
  result_src_e  result_src_w;
  logic         reg_write_w;

  assign opcode_d    = opcode_e'(i_inst_d[6:0]);
  assign funct3_d    = i_inst_d[14:12];
  assign funct7_b5_d = i_inst_d[30];

  main_decoder u_main_decoder (
    .i_opcode      (opcode_d),
    .i_funct3      (funct3_d),
    .o_imm_src     (o_imm_src_d),
    .o_alu_op      (alu_op_d),
    .o_alu_src     (alu_src_d),
    .o_imm_plus_src(imm_plus_src_d),
    .o_mem_req     (mem_req_d),
    .o_mem_write   (mem_write_d),
    .o_mem_size    (mem_sz_d),
    .o_load_signed (load_signed_d),
    .o_result_src  (result_src_d),
    .o_reg_write   (reg_write_d),
    .o_branch      (branch_d),
    .o_jal         (o_jal_d),
    .o_jalr        (jalr_d),
    .o_ecall       (ecall_d)
  );

  alu_decoder u_alu_decoder (
    .i_alu_op   (alu_op_d),
    .i_funct3   (funct3_d),
    .i_opcode_b5(i_inst_d[5]),
    .i_funct7_b5(funct7_b5_d),
    .o_alu_ctrl (alu_ctrl_d)
  );

  // ID/EX register and next pc select
  ex_ctrl_stage u_ex_ctrl_stage (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_flush       (i_flush_e),
    .i_alu_ctrl    (alu_ctrl_d),
    .i_alu_src     (alu_src_d),
    .i_imm_plus_src(imm_plus_src_d),
    .i_ecall       (ecall_d),
    .i_funct3      (funct3_d),
    .i_branch      (branch_d),
    .i_jalr        (jalr_d),
    .i_mem_req     (mem_req_d),
    .i_mem_write   (mem_write_d),
    .i_mem_size    (mem_sz_d),
    .i_load_signed (load_signed_d),
    .i_result_src  (result_src_d),
    .i_reg_write   (reg_write_d),
    .i_zero        (i_zero_e),
    .i_neg         (i_neg_e),
    .i_neg_u       (i_neg_u_e),
    .o_alu_ctrl    (o_alu_ctrl_e),
    .o_alu_src     (o_alu_src_e),
    .o_imm_plus_src(o_imm_plus_src_e),
    .o_result_src  (o_result_src_e),
    .o_pc_src      (o_pc_src_e),
    .o_mem_req     (mem_req_e),
    .o_mem_write   (mem_write_e),
    .o_mem_size    (mem_sz_e),
    .o_load_signed (load_signed_e),
    .o_reg_write   (reg_write_e)
  );

  assign ex_mem_e = '{mem_write: mem_write_e, mem_req: mem_req_e,
                      mem_size: mem_sz_e, load_signed: load_signed_e,
                      result_src: o_result_src_e, reg_write: reg_write_e};

  // EX/MEM
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ex_mem_m <= '0;
    end else begin
      ex_mem_m <= ex_mem_e;
    end
  end

  // MEM/WB keeps only what writeback needs
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      result_src_w <= RES_ALU;
      reg_write_w  <= 1'b0;
    end else begin
      result_src_w <= ex_mem_m.result_src;
      reg_write_w  <= ex_mem_m.reg_write;
    end
  end

  assign o_mem_req_m     = ex_mem_m.mem_req;
  assign o_mem_write_m   = ex_mem_m.mem_write;
  assign o_mem_size_m    = ex_mem_m.mem_size;
  assign o_load_signed_m = ex_mem_m.load_signed;
  assign o_result_src_m  = ex_mem_m.result_src;
  assign o_reg_write_m   = ex_mem_m.reg_write;
  assign o_result_src_w  = result_src_w;
  assign o_reg_write_w   = reg_write_w;

  // write enable moves M to W unchanged
  a_reg_write_m_to_w: assert property (@(posedge clk) disable iff (!i_rst_n)
    $past(i_rst_n) |-> (o_reg_write_w == $past(o_reg_write_m)))
    else $error("pipe_controller: reg_write lost between M and W");

endmodule

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // branch conditions in funct3
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_f3_e;

  // funct3 of OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  // srl and sra told apart by funct7 bit 5
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pipe_controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
  --top-module tb_pipe_controller -o tb_pipe_controller_sim \
  && ./obj_dir/tb_pipe_controller_sim > "$log" 2>&1 \
  || { cat "$log" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$log"
grep -q "TESTBENCH FAILED" "$log" && exit 1
grep -q "TESTBENCH PASSED" "$log" || exit 1
exit 0

// ==== tb.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/ctrl_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/ex_ctrl_stage.sv
logic/pipe_controller.sv
bench/tb_pipe_controller.sv
